// File: hdl/ahbApbBridge_cfg.svh
// Slave regions must not overlap and must end below 4 GB. APB_SLAVES must match the base list.
`ifndef AHB_APB_BRIDGE_CFG_SVH
`define AHB_APB_BRIDGE_CFG_SVH

// ******************************
// APB slave count
// ******************************

`define APB_SLAVES 3

// ******************************
// Address map
// ******************************

// Base of each slave region.
`define SLAVE_BASE0 32'h8000_0000
`define SLAVE_BASE1 32'h8400_0000
`define SLAVE_BASE2 32'h8800_0000

// Every region has the same size.
`define SLAVE_SPAN 32'h0400_0000

`endif

// File: hdl/ahbApbPkg.sv
// Bus widths are fixed at 32 bits. Select width follows APB_SLAVES from the cfg header.
`include "ahbApbBridge_cfg.svh"

package ahbApbPkg;

	// ******************************
	// Bus vectors
	// ******************************

	typedef logic [31:0] addrT;
	typedef logic [31:0] dataT;
	typedef logic [`APB_SLAVES-1:0] pselT; // One-hot APB select.
	typedef logic [1:0] htransT;

	// AHB transfer type encoding.
	localparam htransT TRANS_IDLE   = 2'b00;
	localparam htransT TRANS_BUSY   = 2'b01;
	localparam htransT TRANS_NONSEQ = 2'b10;
	localparam htransT TRANS_SEQ    = 2'b11;

	// ******************************
	// Controller states
	// ******************************

	typedef enum logic [2:0]
	{
		ST_IDLE     = 3'b000,
		ST_WWAIT    = 3'b001, // Write accepted, data phase running.
		ST_READ     = 3'b010, // Read setup.
		ST_WRITE    = 3'b011, // Write setup.
		ST_WRITEP   = 3'b100, // Write setup, next transfer pending.
		ST_RENABLE  = 3'b101,
		ST_WENABLE  = 3'b110,
		ST_WENABLEP = 3'b111  // Write enable, next transfer pending.
	} apbStateE;

endpackage

// File: hdl/ahbSlaveInterface.sv
// Hsize, Hburst and Hprot are not observed. Address and data stages run on every clock edge.
`timescale 1ns/1ps
`include "ahbApbBridge_cfg.svh"

module ahbSlaveInterface
(
	input  logic              Hclk,
	input  logic              Hresetn,
	input  logic              Hselapb,
	input  logic              Hwrite,
	input  logic              Hreadyin,
	input  ahbApbPkg::htransT Htrans,
	input  ahbApbPkg::addrT   Haddr,
	input  ahbApbPkg::dataT   Hwdata,
	output logic              valid,
	output logic              Hwritereg,
	output ahbApbPkg::addrT   Haddr1,
	output ahbApbPkg::addrT   Haddr2,
	output ahbApbPkg::dataT   Hwdata1,
	output ahbApbPkg::dataT   Hwdata2,
	output ahbApbPkg::pselT   tempselx
);
	import ahbApbPkg::*;

	localparam addrT slaveBase [`APB_SLAVES] = '{`SLAVE_BASE0, `SLAVE_BASE1, `SLAVE_BASE2};

	logic active;

	// ******************************
	// Transfer qualification
	// ******************************

	always_comb
	begin
		case (Htrans)
			TRANS_NONSEQ, TRANS_SEQ:
				active = 1'b1;
			TRANS_IDLE, TRANS_BUSY:
				active = 1'b0;
			default:
				active = 1'b0;
		endcase
	end

	// Region hit per slave.
	always_comb
	begin
		for (int i = 0; i < `APB_SLAVES; i++)
		begin
			tempselx[i] = (Haddr >= slaveBase[i]) && ((Haddr - slaveBase[i]) < `SLAVE_SPAN);
		end
	end

	// An address outside every region gives an all-zero select and is dropped.
	assign valid = Hselapb && Hreadyin && active && (|tempselx);

	// ******************************
	// Pipeline stages
	// ******************************

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			Hwritereg <= 1'b0;
		else
			Hwritereg <= Hwrite; // Direction of the last address phase.
	end

	always_ff @(posedge Hclk)
	begin
		Haddr1  <= Haddr;
		Haddr2  <= Haddr1;
		Hwdata1 <= Hwdata;
		Hwdata2 <= Hwdata1;
	end

endmodule

// File: hdl/apbFsmController.sv
// Hreadyin must be tied to Hreadyout. APB slaves are zero-wait with no Pready or Pslverr.
`timescale 1ns/1ps

module apbFsmController
(
	input  logic            Hclk,
	input  logic            Hresetn,
	input  logic            valid,
	input  logic            Hwrite,
	input  logic            Hwritereg,
	input  ahbApbPkg::addrT Haddr,
	input  ahbApbPkg::addrT Haddr1,
	input  ahbApbPkg::addrT Haddr2,
	input  ahbApbPkg::dataT Hwdata,
	input  ahbApbPkg::pselT tempselx,
	output logic            Pwrite,
	output logic            Penable,
	output logic            Hreadyout,
	output ahbApbPkg::pselT Pselx,
	output ahbApbPkg::addrT Paddr,
	output ahbApbPkg::dataT Pwdata
);
	import ahbApbPkg::*;

	apbStateE state;
	apbStateE nextState;

	pselT selPend; // Select of the last accepted transfer.

	logic pwriteNxt;
	logic penableNxt;
	logic hreadyoutNxt;
	pselT pselxNxt;
	addrT paddrNxt;
	dataT pwdataNxt;

	// ******************************
	// State register
	// ******************************

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			state <= ST_IDLE;
		else
			state <= nextState;
	end

	// Writes start a cycle after acceptance, so their select is kept here.
	always_ff @(posedge Hclk)
	begin
		if (valid)
			selPend <= tempselx;
	end

	// ******************************
	// Next state
	// ******************************

	always_comb
	begin
		nextState = ST_IDLE;
		case (state)
			ST_IDLE, ST_RENABLE, ST_WENABLE:
			begin
				if (!valid)
					nextState = ST_IDLE;
				else if (Hwrite)
					nextState = ST_WWAIT;
				else
					nextState = ST_READ;
			end
			ST_WWAIT:
			begin
				if (valid)
					nextState = ST_WRITEP;
				else
					nextState = ST_WRITE;
			end
			ST_READ:
				nextState = ST_RENABLE;
			ST_WRITE:
				nextState = ST_WENABLE;
			ST_WRITEP:
				nextState = ST_WENABLEP;
			ST_WENABLEP:
			begin
				// Low Hreadyout here means the pending transfer is a read.
				if (!Hreadyout)
					nextState = ST_READ;
				else if (valid)
					nextState = ST_WRITEP;
				else
					nextState = ST_WRITE;
			end
			default:
				nextState = ST_IDLE;
		endcase
	end

	// ******************************
	// Output decode
	// ******************************

	always_comb
	begin
		pselxNxt     = Pselx;
		paddrNxt     = Paddr;
		pwriteNxt    = Pwrite;
		pwdataNxt    = Pwdata;
		penableNxt   = Penable;
		hreadyoutNxt = Hreadyout;
		case (state)
			ST_IDLE, ST_RENABLE, ST_WENABLE:
			begin
				penableNxt = 1'b0;
				if (valid && !Hwrite)
				begin
					// Read goes straight to setup.
					pselxNxt     = tempselx;
					paddrNxt     = Haddr;
					pwriteNxt    = 1'b0;
					hreadyoutNxt = 1'b0;
				end
				else
				begin
					pselxNxt     = '0;
					hreadyoutNxt = 1'b1;
				end
			end
			ST_WWAIT:
			begin
				pselxNxt     = selPend;
				paddrNxt     = Haddr1; // Address from one cycle back.
				pwriteNxt    = 1'b1;
				pwdataNxt    = Hwdata;
				penableNxt   = 1'b0;
				hreadyoutNxt = 1'b0;
			end
			ST_READ, ST_WRITE:
			begin
				penableNxt   = 1'b1;
				hreadyoutNxt = 1'b1;
			end
			ST_WRITEP:
			begin
				penableNxt   = 1'b1;
				hreadyoutNxt = Hwritereg; // A pending read keeps the master stalled.
			end
			ST_WENABLEP:
			begin
				pselxNxt     = selPend;
				paddrNxt     = Haddr2;
				pwriteNxt    = Hreadyout;
				penableNxt   = 1'b0;
				hreadyoutNxt = 1'b0;
				if (Hreadyout)
					pwdataNxt = Hwdata;
			end
			default:
			begin
				pselxNxt     = '0;
				penableNxt   = 1'b0;
				hreadyoutNxt = 1'b1;
			end
		endcase
	end

	// ******************************
	// Output registers
	// ******************************

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			Pselx     <= '0;
			Pwrite    <= 1'b0;
			Penable   <= 1'b0;
			Hreadyout <= 1'b1;
		end
		else
		begin
			Pselx     <= pselxNxt;
			Pwrite    <= pwriteNxt;
			Penable   <= penableNxt;
			Hreadyout <= hreadyoutNxt;
		end
	end

	always_ff @(posedge Hclk)
	begin
		Paddr  <= paddrNxt;
		Pwdata <= pwdataNxt;
	end

endmodule

// File: hdl/ahbApbBridge.sv
// Hreadyin must be tied to Hreadyout by the master. Hresp is always OKAY and has no port.
`timescale 1ns/1ps

module ahbApbBridge
(
	input  logic              Hclk,
	input  logic              Hresetn,
	input  logic              Hselapb,
	input  logic              Hwrite,
	input  logic              Hreadyin,
	input  ahbApbPkg::htransT Htrans,
	input  ahbApbPkg::addrT   Haddr,
	input  ahbApbPkg::dataT   Hwdata,
	input  ahbApbPkg::dataT   Prdata,
	output logic              Hreadyout,
	output ahbApbPkg::dataT   Hrdata,
	output ahbApbPkg::pselT   Pselx,
	output ahbApbPkg::addrT   Paddr,
	output logic              Pwrite,
	output logic              Penable,
	output ahbApbPkg::dataT   Pwdata
);
	import ahbApbPkg::*;

	logic valid;
	logic Hwritereg;
	addrT Haddr1;
	addrT Haddr2;
	pselT tempselx;

	// ******************************
	// AHB side
	// ******************************

	ahbSlaveInterface ahbIf0
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.Hselapb   (Hselapb),
		.Hwrite    (Hwrite),
		.Hreadyin  (Hreadyin),
		.Htrans    (Htrans),
		.Haddr     (Haddr),
		.Hwdata    (Hwdata),
		.valid     (valid),
		.Hwritereg (Hwritereg),
		.Haddr1    (Haddr1),
		.Haddr2    (Haddr2),
		.Hwdata1   (),
		.Hwdata2   (),
		.tempselx  (tempselx)
	);

	// ******************************
	// APB side
	// ******************************

	apbFsmController apbCtrl0
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.valid     (valid),
		.Hwrite    (Hwrite),
		.Hwritereg (Hwritereg),
		.Haddr     (Haddr),
		.Haddr1    (Haddr1),
		.Haddr2    (Haddr2),
		.Hwdata    (Hwdata),
		.tempselx  (tempselx),
		.Pwrite    (Pwrite),
		.Penable   (Penable),
		.Hreadyout (Hreadyout),
		.Pselx     (Pselx),
		.Paddr     (Paddr),
		.Pwdata    (Pwdata)
	);

	assign Hrdata = Prdata; // Read data is valid in the enable cycle.

endmodule

// File: sim/ahbApbBridge_assert.sv
// Checks APB framing only. Sampled on the rising edge, idle during reset.
`timescale 1ns/1ps

module ahbApbBridgeAssert
(
	input logic            Hclk,
	input logic            Hresetn,
	input ahbApbPkg::pselT Pselx,
	input ahbApbPkg::addrT Paddr,
	input logic            Pwrite,
	input logic            Penable
);
	int unsigned failCount = 0; // Failed assertions so far.

	// ******************************
	// APB framing
	// ******************************

	selOneHot: assert property (@(posedge Hclk) disable iff (!Hresetn) $onehot0(Pselx))
	else
	begin
		failCount++;
		$error("Pselx has more than one bit set.");
	end

	enableNeedsSel: assert property (@(posedge Hclk) disable iff (!Hresetn) Penable |-> |Pselx)
	else
	begin
		failCount++;
		$error("Penable is high with no slave selected.");
	end

	// Setup is followed by enable with the access held.
	setupToEnable: assert property (@(posedge Hclk) disable iff (!Hresetn)
		(|Pselx && !Penable) |=> (Penable && $stable(Paddr) && $stable(Pwrite) && $stable(Pselx)))
	else
	begin
		failCount++;
		$error("Setup cycle not followed by a matching enable cycle.");
	end

	enableOneCycle: assert property (@(posedge Hclk) disable iff (!Hresetn) Penable |=> !Penable)
	else
	begin
		failCount++;
		$error("Penable stayed high for two cycles.");
	end

endmodule

bind ahbApbBridge ahbApbBridgeAssert assert0
(
	.Hclk    (Hclk),
	.Hresetn (Hresetn),
	.Pselx   (Pselx),
	.Paddr   (Paddr),
	.Pwrite  (Pwrite),
	.Penable (Penable)
);

// File: sim/ahbApbBridgeTb.sv
// Hreadyin is tied to Hreadyout. Slave models hold 16 words per region, indexed by Paddr[5:2].
`timescale 1ns/1ps
`include "ahbApbBridge_cfg.svh"

module ahbApbBridgeTb;
	import ahbApbPkg::*;

	localparam int waitLimit = 50;
	localparam addrT regionBase [`APB_SLAVES] = '{`SLAVE_BASE0, `SLAVE_BASE1, `SLAVE_BASE2};

	logic   Hclk;
	logic   Hresetn;
	logic   Hselapb;
	logic   Hwrite;
	logic   Hreadyout;
	htransT Htrans;
	addrT   Haddr;
	dataT   Hwdata;
	dataT   Hrdata;
	dataT   Prdata;
	pselT   Pselx;
	addrT   Paddr;
	logic   Pwrite;
	logic   Penable;
	dataT   Pwdata;

	dataT slaveMem [`APB_SLAVES][16];
	dataT refMem [`APB_SLAVES][16]; // Expected slave contents.
	logic [15:0] lfsr = 16'd62;
	pselT monSel [$];
	addrT monAddr [$];
	logic monWrite [$];
	dataT monData [$];

	ahbApbBridge dut0 (.Hreadyin(Hreadyout), .*);

	initial
	begin
		Hclk = 1'b0;
		forever #10 Hclk = ~Hclk;
	end

	// ******************************
	// APB slave models and monitor
	// ******************************

	always_comb
	begin
		Prdata = '0;
		for (int s = 0; s < `APB_SLAVES; s++)
			if (Pselx[s])
				Prdata = slaveMem[s][Paddr[5:2]];
	end

	// Enable cycle is stable at the falling edge.
	always @(negedge Hclk)
	begin
		if (Hresetn && Penable)
		begin
			monSel.push_back(Pselx);
			monAddr.push_back(Paddr);
			monWrite.push_back(Pwrite);
			monData.push_back(Pwdata);
			for (int s = 0; s < `APB_SLAVES; s++)
				if (Pselx[s] && Pwrite)
					slaveMem[s][Paddr[5:2]] = Pwdata;
		end
		if (dut0.assert0.failCount != 0)
			failRun("A bound APB protocol assertion failed.");
	end

	// ******************************
	// Helpers
	// ******************************

	// Fibonacci LFSR, taps 16 14 13 11.
	function automatic logic lfsrStep();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] randomWord(int width);
		logic [31:0] w;
		w = '0;
		for (int b = 0; b < width; b++)
			w = {w[30:0], lfsrStep()};
		return w;
	endfunction

	function automatic addrT randomAddr(int r);
		return regionBase[r] | (randomWord(26) & 32'h03FF_FFFC); // Word aligned, inside region r.
	endfunction

	task automatic failRun(string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
		assert (got === exp)
		else
			failRun($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
	endtask

	// The phase on the bus ends at the next rising edge once this returns.
	task automatic waitReady();
		int n;
		n = 0;
		while (Hreadyout !== 1'b1)
		begin
			@(negedge Hclk);
			n++;
			if (n > waitLimit)
				failRun("Timeout while waiting for Hreadyout to rise.");
		end
	endtask

	task automatic waitApbIdle();
		int n;
		int quiet;
		n = 0;
		quiet = 0;
		while (quiet < 2)
		begin
			@(negedge Hclk);
			n++;
			quiet = (Pselx == '0 && !Penable && Hreadyout) ? quiet + 1 : 0;
			if (n > waitLimit)
				failRun("Timeout while waiting for the APB side to go idle.");
		end
	endtask

	// Address i goes out together with the data of address i-1.
	task automatic writeBurst(addrT addrs [$], dataT datas [$]);
		for (int i = 0; i <= addrs.size(); i++)
		begin
			if (i < addrs.size())
			begin
				Hselapb = 1'b1;
				Htrans  = TRANS_NONSEQ;
				Hwrite  = 1'b1;
				Haddr   = addrs[i];
			end
			else
				Htrans = TRANS_IDLE;
			if (i > 0)
				Hwdata = datas[i-1];
			waitReady();
			@(negedge Hclk);
		end
	endtask

	task automatic readWord(addrT a, output dataT d);
		Hselapb = 1'b1;
		Htrans  = TRANS_NONSEQ;
		Hwrite  = 1'b0;
		Haddr   = a;
		waitReady();
		@(negedge Hclk);
		Htrans = TRANS_IDLE;
		waitReady();
		checkValue("Pwrite", Pwrite, 1'b0);
		checkValue("Penable", Penable, 1'b1);
		d = Hrdata;
		@(negedge Hclk);
	endtask

	task automatic checkAccess(pselT sel, addrT a, logic wr, dataT d);
		assert (monSel.size() > 0)
		else
			failRun("An expected APB access did not take place.");
		checkValue("Pselx", monSel.pop_front(), sel);
		checkValue("Paddr", monAddr.pop_front(), a);
		checkValue("Pwrite", monWrite.pop_front(), wr);
		if (wr)
			checkValue("Pwdata", monData.pop_front(), d);
		else
			void'(monData.pop_front());
	endtask

	task automatic writeOne(int r, output addrT a);
		addrT q [$];
		dataT d [$];
		a = randomAddr(r);
		q.push_back(a);
		d.push_back(randomWord(32));
		writeBurst(q, d);
		waitApbIdle();
		checkAccess(pselT'(1) << r, a, 1'b1, d[0]);
		assert (monSel.size() == 0)
		else
			failRun("A single write caused more than one APB access.");
		refMem[r][a[5:2]] = d[0];
	endtask

	task automatic readCheck(int r, addrT a);
		dataT d;
		readWord(a, d);
		checkValue("Hrdata", d, refMem[r][a[5:2]]);
		waitApbIdle();
		checkAccess(pselT'(1) << r, a, 1'b0, '0);
	endtask

	task automatic ignoredTransfer(logic sel, htransT t, addrT a, logic wr);
		Hselapb = sel;
		Htrans  = t;
		Hwrite  = wr;
		Haddr   = a;
		@(negedge Hclk);
		Htrans  = TRANS_IDLE;
		Hselapb = 1'b0;
		for (int n = 0; n < 10; n++)
		begin
			assert (Pselx == '0 && !Penable && Hreadyout)
			else
				failRun("An ignored transfer started APB activity or stalled the master.");
			@(negedge Hclk);
		end
		assert (monSel.size() == 0)
		else
			failRun("An ignored transfer reached an APB slave.");
	endtask

	// ******************************
	// Tests
	// ******************************

	task automatic testReset();
		checkValue("Pselx", Pselx, '0);
		checkValue("Penable", Penable, 1'b0);
		checkValue("Pwrite", Pwrite, 1'b0);
		checkValue("Hreadyout", Hreadyout, 1'b1);
	endtask

	task automatic testDecode();
		addrT a [`APB_SLAVES];
		for (int r = 0; r < `APB_SLAVES; r++)
			writeOne(r, a[r]);
		for (int r = 0; r < `APB_SLAVES; r++)
			readCheck(r, a[r]);
	endtask

	task automatic testPipelined();
		addrT q [$];
		dataT d [$];
		int rg [$];
		for (int i = 0; i < 8; i++)
		begin
			rg.push_back(randomWord(2) % `APB_SLAVES);
			q.push_back(randomAddr(rg[i]));
			d.push_back(randomWord(32));
		end
		writeBurst(q, d);
		waitApbIdle();
		for (int i = 0; i < 8; i++)
		begin
			checkAccess(pselT'(1) << rg[i], q[i], 1'b1, d[i]);
			refMem[rg[i]][q[i][5:2]] = d[i]; // Later writes to one word win.
		end
		for (int i = 0; i < 8; i++)
			readCheck(rg[i], q[i]);
	endtask

	task automatic testIgnored();
		ignoredTransfer(1'b1, TRANS_IDLE, randomAddr(1), 1'b1);
		ignoredTransfer(1'b0, TRANS_NONSEQ, randomAddr(2), 1'b0);
		ignoredTransfer(1'b1, TRANS_NONSEQ, 32'h7FFF_FFFC, 1'b1);
		ignoredTransfer(1'b1, TRANS_NONSEQ, `SLAVE_BASE2 + `SLAVE_SPAN, 1'b0);
	endtask

	initial
	begin
		addrT firstAddr;
		Hresetn = 1'b0;
		Hselapb = 1'b0;
		Hwrite  = 1'b0;
		Htrans  = TRANS_IDLE;
		Haddr   = '0;
		Hwdata  = '0;
		for (int s = 0; s < `APB_SLAVES; s++)
			for (int i = 0; i < 16; i++)
			begin
				slaveMem[s][i] = ~(regionBase[s] | (i << 2));
				refMem[s][i]   = ~(regionBase[s] | (i << 2));
			end
		repeat (8) @(posedge Hclk); // Eight clock edges in reset.
		@(negedge Hclk);
		Hresetn = 1'b1;
		@(negedge Hclk);
		testReset();
		writeOne(0, firstAddr);
		readCheck(0, firstAddr);
		testDecode();
		testPipelined();
		testIgnored();
		if (dut0.assert0.failCount == 0)
			$display("TESTBENCH PASSED");
		else
		begin
			$display("APB protocol assertions failed %0d times.", dut0.assert0.failCount);
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: ahbApbBridge.f
+incdir+hdl
hdl/ahbApbPkg.sv
hdl/ahbSlaveInterface.sv
hdl/apbFsmController.sv
hdl/ahbApbBridge.sv
sim/ahbApbBridge_assert.sv
sim/ahbApbBridgeTb.sv

// File: Bender.yml
package:
  name: ahb_apb_bridge

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ahbApbPkg.sv
      - hdl/ahbSlaveInterface.sv
      - hdl/apbFsmController.sv
      - hdl/ahbApbBridge.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/ahbApbBridge_assert.sv
      - sim/ahbApbBridgeTb.sv
